//--- hbm_read_top.f
source/hbm_cfg_pkg.sv
source/hbm_types_pkg.sv
source/hbm_start_ctrl.sv
source/hbm_araddr_gen.sv
source/hbm_chan_fifo.sv
source/hbm_engine_merge.sv
source/hbm_read_top.sv
verif/hbm_mem_model.sv
verif/tb_hbm_read_top.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
        --top-module tb_hbm_read_top -f hbm_read_top.f -o tb_hbm_read_top \
    && ./obj_dir/tb_hbm_read_top | tee /dev/stderr | grep -x "No errors" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- source/hbm_araddr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module hbm_araddr_gen (
    input  wire                            hbm_clk,
    input  wire                            hbm_rstn,
    input  wire                            run_start_i,
    input  wire hbm_types_pkg::burst_cnt_t burst_cnt_i,   // stable over the run
    input  wire hbm_types_pkg::hbm_addr_t  stride_i,      // stable over the run
    output logic                           ar_valid_o,
    output hbm_types_pkg::ar_req_t         ar_o,
    input  wire                            ar_ready_i
);

    hbm_types_pkg::ar_state_e  state;
    hbm_types_pkg::hbm_addr_t  addr_acc;   // address of the pending request
    hbm_types_pkg::burst_cnt_t issued;     // accepted so far

    assign ar_valid_o = (state == hbm_types_pkg::AR_ISSUE);
    assign ar_o       = '{addr: addr_acc, len: 8'(hbm_cfg_pkg::BURST_BEATS - 1)};

    //////////////////////////////////////////////////
    // burst issue

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            state    <= hbm_types_pkg::AR_IDLE;
            addr_acc <= '0;
            issued   <= '0;
        end else begin
            case (state)
                hbm_types_pkg::AR_IDLE, hbm_types_pkg::AR_DONE: begin
                    if (run_start_i) begin
                        addr_acc <= '0;                 // runs start at base 0
                        issued   <= '0;
                        state    <= (burst_cnt_i == '0) ? hbm_types_pkg::AR_DONE
                                                        : hbm_types_pkg::AR_ISSUE;
                    end
                end
                hbm_types_pkg::AR_ISSUE: begin
                    if (ar_ready_i) begin              // handshake, step to next burst
                        issued   <= issued + 1'b1;
                        addr_acc <= addr_acc + stride_i;
                        if (issued == burst_cnt_i - 1'b1) state <= hbm_types_pkg::AR_DONE;
                    end
                end
                default: state <= hbm_types_pkg::AR_IDLE;
            endcase
        end
    end

    // held request under arready backpressure
    a_ar_hold: assert property (@(posedge hbm_clk) disable iff (!hbm_rstn)
        (ar_valid_o && !ar_ready_i) |=> (ar_valid_o && $stable(ar_o)));

endmodule

`default_nettype wire

//--- source/hbm_cfg_pkg.sv
`default_nettype none

package hbm_cfg_pkg;

    //////////////////////////////////////////////////
    // topology

    localparam int ENGINE_NUM       = 2;                              // downstream engines
    localparam int CHANS_PER_ENGINE = 2;                              // merged per engine
    localparam int CHAN_NUM         = ENGINE_NUM * CHANS_PER_ENGINE;  // hbm pseudo-channels

    //////////////////////////////////////////////////
    // datapath widths

    localparam int CHAN_DATA_W   = 64;                                // one rdata beat
    localparam int ENGINE_DATA_W = 128;                               // channel pair side by side
    localparam int HBM_ADDR_W    = 33;                                // 8G byte space

    //////////////////////////////////////////////////
    // read bursts and buffering

    localparam int BURST_BEATS = 4;                                   // arlen + 1
    localparam int BURST_CNT_W = 16;                                  // bursts per channel per run
    localparam int FIFO_DEPTH  = 16;                                  // power of two, pointers wrap

    // credits the engine owns out of reset
    localparam int CREDIT_MAX = 4;

    // start_um width toward the engine
    localparam int START_UM_CYCLES = 3;

endpackage

`default_nettype wire

//--- source/hbm_chan_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module hbm_chan_fifo (
    input  wire                            hbm_clk,
    input  wire                            hbm_rstn,
    input  wire                            r_valid_i,
    input  wire hbm_types_pkg::r_beat_t    r_i,          // rlast unused, merge counts beats
    output logic                           r_ready_o,
    output hbm_types_pkg::chan_data_t      head_o,
    output logic                           not_empty_o,
    input  wire                            pop_i
);

    hbm_types_pkg::chan_data_t mem [hbm_cfg_pkg::FIFO_DEPTH];
    hbm_types_pkg::fifo_ptr_t  wr_ptr, rd_ptr;   // wrap by width
    hbm_types_pkg::fifo_cnt_t  cnt, cnt_next;
    logic                      push;

    assign push        = r_valid_i && r_ready_o;   // rdata handshake
    assign cnt_next    = cnt + hbm_types_pkg::fifo_cnt_t'(push)
                             - hbm_types_pkg::fifo_cnt_t'(pop_i);
    assign head_o      = mem[rd_ptr];                // show-ahead
    assign not_empty_o = (cnt != '0);

    //////////////////////////////////////////////////
    // pointers and occupancy

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            cnt       <= '0;
            r_ready_o <= 1'b0;
        end else begin
            if (push)  wr_ptr <= wr_ptr + 1'b1;
            if (pop_i) rd_ptr <= rd_ptr + 1'b1;
            cnt       <= cnt_next;
            // ready while an entry is free next cycle
            r_ready_o <= (cnt_next != hbm_types_pkg::fifo_cnt_t'(hbm_cfg_pkg::FIFO_DEPTH));
        end
    end

    // storage
    always_ff @(posedge hbm_clk) begin
        if (push) mem[wr_ptr] <= r_i.data;
    end

    // merge must wait for both sides
    a_no_underflow: assert property (@(posedge hbm_clk) disable iff (!hbm_rstn)
        pop_i |-> not_empty_o);

endmodule

`default_nettype wire

//--- source/hbm_engine_merge.sv
`timescale 1ns/1ps
`default_nettype none

module hbm_engine_merge (
    input  wire                            hbm_clk,
    input  wire                            hbm_rstn,
    input  wire                            run_start_i,
    input  wire hbm_types_pkg::burst_cnt_t burst_cnt_i,
    input  wire hbm_types_pkg::chan_data_t head0_i,       // even channel
    input  wire hbm_types_pkg::chan_data_t head1_i,       // odd channel
    input  wire                            not_empty0_i,
    input  wire                            not_empty1_i,
    output logic                           pop_o,
    output logic                           eng_valid_o,
    output hbm_types_pkg::engine_data_t    eng_data_o,
    input  wire                            eng_credit_i,  // one pulse per consumed word
    output logic                           eng_done_o
);

    hbm_types_pkg::credit_t   credit;
    hbm_types_pkg::word_cnt_t word_cnt;      // words popped this run
    hbm_types_pkg::word_cnt_t word_target;

    assign word_target = hbm_types_pkg::word_cnt_t'(burst_cnt_i)
                       * hbm_types_pkg::word_cnt_t'(hbm_cfg_pkg::BURST_BEATS);

    // both heads present and engine has room
    assign pop_o = not_empty0_i && not_empty1_i && (credit != '0);

    //////////////////////////////////////////////////
    // credits, word count, done

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            credit      <= hbm_types_pkg::credit_t'(hbm_cfg_pkg::CREDIT_MAX);
            word_cnt    <= '0;
            eng_valid_o <= 1'b0;
            eng_done_o  <= 1'b1;                 // idle engine has nothing pending
        end else begin
            credit      <= credit - hbm_types_pkg::credit_t'(pop_o)
                                  + hbm_types_pkg::credit_t'(eng_credit_i);
            eng_valid_o <= pop_o;                // word lands one cycle after pop
            if (run_start_i) begin
                word_cnt   <= '0;
                eng_done_o <= 1'b0;
            end else begin
                if (pop_o) word_cnt <= word_cnt + 1'b1;
                if (word_cnt == word_target) eng_done_o <= 1'b1;
            end
        end
    end

    // payload, ch1 high / ch0 low
    always_ff @(posedge hbm_clk) begin
        if (pop_o) eng_data_o <= {head1_i, head0_i};
    end

    // engine returns no more than it was given
    a_credit_max: assert property (@(posedge hbm_clk) disable iff (!hbm_rstn)
        credit <= hbm_types_pkg::credit_t'(hbm_cfg_pkg::CREDIT_MAX));

endmodule

`default_nettype wire

//--- source/hbm_read_top.sv
`timescale 1ns/1ps
`default_nettype none

module hbm_read_top (
    input  wire                                                          hbm_clk,
    input  wire                                                          hbm_rstn,
    input  wire                                                          start_i,
    input  wire hbm_types_pkg::burst_cnt_t                               burst_cnt_i,
    input  wire hbm_types_pkg::hbm_addr_t                                stride_i,
    // hbm read address, one per pseudo-channel
    output wire [hbm_cfg_pkg::CHAN_NUM-1:0]                              ar_valid_o,
    output wire hbm_types_pkg::ar_req_t [hbm_cfg_pkg::CHAN_NUM-1:0]      ar_o,
    input  wire [hbm_cfg_pkg::CHAN_NUM-1:0]                              ar_ready_i,
    // hbm read data
    input  wire [hbm_cfg_pkg::CHAN_NUM-1:0]                              r_valid_i,
    input  wire hbm_types_pkg::r_beat_t [hbm_cfg_pkg::CHAN_NUM-1:0]      r_i,
    output wire [hbm_cfg_pkg::CHAN_NUM-1:0]                              r_ready_o,
    // toward the engines, credit based
    output wire [hbm_cfg_pkg::ENGINE_NUM-1:0]                            eng_valid_o,
    output wire hbm_types_pkg::engine_data_t [hbm_cfg_pkg::ENGINE_NUM-1:0] eng_data_o,
    input  wire [hbm_cfg_pkg::ENGINE_NUM-1:0]                            eng_credit_i,
    output wire                                                          start_um_o,
    output wire                                                          busy_o
);

    wire                                                     run_start;  // one cycle, all channels
    wire [hbm_cfg_pkg::ENGINE_NUM-1:0]                       eng_done;
    wire [hbm_cfg_pkg::ENGINE_NUM-1:0]                       pop;        // shared by a fifo pair
    wire hbm_types_pkg::chan_data_t [hbm_cfg_pkg::CHAN_NUM-1:0] head;
    wire [hbm_cfg_pkg::CHAN_NUM-1:0]                         not_empty;

    hbm_start_ctrl start_ctrl_inst (
        .hbm_clk     (hbm_clk),
        .hbm_rstn    (hbm_rstn),
        .start_i     (start_i),
        .eng_done_i  (eng_done),
        .run_start_o (run_start),
        .start_um_o  (start_um_o),
        .busy_o      (busy_o)
    );

    //////////////////////////////////////////////////
    // per engine: two channels, one merge

    genvar e, c;
    generate
        for (e = 0; e < hbm_cfg_pkg::ENGINE_NUM; e++) begin : g_engine
            for (c = 0; c < hbm_cfg_pkg::CHANS_PER_ENGINE; c++) begin : g_chan
                hbm_araddr_gen araddr_gen_inst (
                    .hbm_clk     (hbm_clk),
                    .hbm_rstn    (hbm_rstn),
                    .run_start_i (run_start),
                    .burst_cnt_i (burst_cnt_i),
                    .stride_i    (stride_i),
                    .ar_valid_o  (ar_valid_o[e*hbm_cfg_pkg::CHANS_PER_ENGINE+c]),
                    .ar_o        (ar_o[e*hbm_cfg_pkg::CHANS_PER_ENGINE+c]),
                    .ar_ready_i  (ar_ready_i[e*hbm_cfg_pkg::CHANS_PER_ENGINE+c])
                );

                hbm_chan_fifo chan_fifo_inst (
                    .hbm_clk     (hbm_clk),
                    .hbm_rstn    (hbm_rstn),
                    .r_valid_i   (r_valid_i[e*hbm_cfg_pkg::CHANS_PER_ENGINE+c]),
                    .r_i         (r_i[e*hbm_cfg_pkg::CHANS_PER_ENGINE+c]),
                    .r_ready_o   (r_ready_o[e*hbm_cfg_pkg::CHANS_PER_ENGINE+c]),
                    .head_o      (head[e*hbm_cfg_pkg::CHANS_PER_ENGINE+c]),
                    .not_empty_o (not_empty[e*hbm_cfg_pkg::CHANS_PER_ENGINE+c]),
                    .pop_i       (pop[e])                   // both fifos drain together
                );
            end

            hbm_engine_merge engine_merge_inst (
                .hbm_clk      (hbm_clk),
                .hbm_rstn     (hbm_rstn),
                .run_start_i  (run_start),
                .burst_cnt_i  (burst_cnt_i),
                .head0_i      (head[e*hbm_cfg_pkg::CHANS_PER_ENGINE]),      // lower half
                .head1_i      (head[e*hbm_cfg_pkg::CHANS_PER_ENGINE+1]),    // upper half
                .not_empty0_i (not_empty[e*hbm_cfg_pkg::CHANS_PER_ENGINE]),
                .not_empty1_i (not_empty[e*hbm_cfg_pkg::CHANS_PER_ENGINE+1]),
                .pop_o        (pop[e]),
                .eng_valid_o  (eng_valid_o[e]),
                .eng_data_o   (eng_data_o[e]),
                .eng_credit_i (eng_credit_i[e]),
                .eng_done_o   (eng_done[e])
            );
        end
    endgenerate

endmodule

`default_nettype wire

//--- source/hbm_start_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module hbm_start_ctrl (
    input  wire                                hbm_clk,
    input  wire                                hbm_rstn,
    input  wire                                start_i,      // asynchronous level
    input  wire [hbm_cfg_pkg::ENGINE_NUM-1:0]  eng_done_i,
    output logic                               run_start_o,
    output logic                               start_um_o,
    output logic                               busy_o
);

    logic                                            start_d1, start_d2;
    logic                                            launch;
    logic [$clog2(hbm_cfg_pkg::START_UM_CYCLES+1)-1:0] um_cnt;   // remaining start_um cycles
    hbm_types_pkg::run_state_e                       state;

    // rising edge seen only from idle
    assign launch = start_d1 && !start_d2 && (state == hbm_types_pkg::IDLE);
    assign busy_o = (state == hbm_types_pkg::RUN);

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            start_d1    <= 1'b0;
            start_d2    <= 1'b0;
            run_start_o <= 1'b0;
            state       <= hbm_types_pkg::IDLE;
        end else begin
            start_d1    <= start_i;
            start_d2    <= start_d1;
            run_start_o <= launch;
            case (state)
                hbm_types_pkg::IDLE: if (run_start_o) state <= hbm_types_pkg::RUN;
                hbm_types_pkg::RUN:  if (&eng_done_i) state <= hbm_types_pkg::IDLE; // all drained
                default:             state <= hbm_types_pkg::IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // start_um stretch aligned with run_start_o

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            um_cnt     <= '0;
            start_um_o <= 1'b0;
        end else if (launch) begin
            um_cnt     <= $bits(um_cnt)'(hbm_cfg_pkg::START_UM_CYCLES - 1);
            start_um_o <= 1'b1;
        end else begin
            start_um_o <= (um_cnt != '0);
            if (um_cnt != '0) um_cnt <= um_cnt - 1'b1;
        end
    end

    // pulse length seen by the engine
    a_um_len: assert property (@(posedge hbm_clk) disable iff (!hbm_rstn)
        start_um_o [*hbm_cfg_pkg::START_UM_CYCLES] |=> !start_um_o);

endmodule

`default_nettype wire

//--- source/hbm_types_pkg.sv
`default_nettype none

package hbm_types_pkg;

    //////////////////////////////////////////////////
    // vectors

    typedef logic [hbm_cfg_pkg::HBM_ADDR_W-1:0]    hbm_addr_t;    // byte address
    typedef logic [hbm_cfg_pkg::CHAN_DATA_W-1:0]   chan_data_t;   // one channel beat
    typedef logic [hbm_cfg_pkg::ENGINE_DATA_W-1:0] engine_data_t; // merged word
    typedef logic [hbm_cfg_pkg::BURST_CNT_W-1:0]   burst_cnt_t;

    // counts up to CREDIT_MAX inclusive
    typedef logic [$clog2(hbm_cfg_pkg::CREDIT_MAX+1)-1:0] credit_t;

    // words per run, burst count times beats
    typedef logic [hbm_cfg_pkg::BURST_CNT_W+$clog2(hbm_cfg_pkg::BURST_BEATS)-1:0] word_cnt_t;

    typedef logic [$clog2(hbm_cfg_pkg::FIFO_DEPTH)-1:0]   fifo_ptr_t;
    typedef logic [$clog2(hbm_cfg_pkg::FIFO_DEPTH+1)-1:0] fifo_cnt_t;  // 0..DEPTH

    //////////////////////////////////////////////////
    // axi read channels

    typedef struct packed {
        hbm_addr_t  addr;   // araddr
        logic [7:0] len;    // arlen, beats - 1
    } ar_req_t;

    typedef struct packed {
        chan_data_t data;   // rdata
        logic       last;   // rlast
    } r_beat_t;

    //////////////////////////////////////////////////
    // state machines

    typedef enum logic {
        IDLE,
        RUN
    } run_state_e;

    typedef enum logic [1:0] {
        AR_IDLE,
        AR_ISSUE,
        AR_DONE
    } ar_state_e;

endpackage

`default_nettype wire

//--- verif/hbm_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module hbm_mem_model (
    input  wire                                                     hbm_clk,
    input  wire                                                     hbm_rstn,
    input  wire [hbm_cfg_pkg::CHAN_NUM-1:0]                         ar_valid_i,
    input  wire hbm_types_pkg::ar_req_t [hbm_cfg_pkg::CHAN_NUM-1:0] ar_i,
    output logic [hbm_cfg_pkg::CHAN_NUM-1:0]                        ar_ready_o,
    output logic [hbm_cfg_pkg::CHAN_NUM-1:0]                        r_valid_o,
    output hbm_types_pkg::r_beat_t [hbm_cfg_pkg::CHAN_NUM-1:0]      r_o,
    input  wire [hbm_cfg_pkg::CHAN_NUM-1:0]                         r_ready_i
);

    localparam int Q_DEPTH = 64;    // outstanding bursts per channel

    integer                   seed;
    hbm_types_pkg::hbm_addr_t ar_q [hbm_cfg_pkg::CHAN_NUM][Q_DEPTH];
    int                       q_wr [hbm_cfg_pkg::CHAN_NUM];
    int                       q_rd [hbm_cfg_pkg::CHAN_NUM];
    int                       beat [hbm_cfg_pkg::CHAN_NUM];    // beat within head burst
    hbm_types_pkg::hbm_addr_t addr;

    //////////////////////////////////////////////////
    // pseudo-channels, random stalls on ar and r

    initial begin
        seed       = 56;
        ar_ready_o = '0;
        r_valid_o  = '0;
        r_o        = '0;
        forever begin
            @(posedge hbm_clk);
            for (int c = 0; c < hbm_cfg_pkg::CHAN_NUM; c++) begin
                if (!hbm_rstn) begin
                    q_wr[c]       = 0;
                    q_rd[c]       = 0;
                    beat[c]       = 0;
                    ar_ready_o[c] <= 1'b0;
                    r_valid_o[c]  <= 1'b0;
                end else begin
                    if (ar_valid_i[c] && ar_ready_o[c]) begin      // burst accepted
                        ar_q[c][q_wr[c] % Q_DEPTH] = ar_i[c].addr;
                        q_wr[c]++;
                    end
                    ar_ready_o[c] <= (($random(seed) & 3) != 0);  // about 1 in 4 stalls
                    if (r_valid_o[c] && r_ready_i[c]) begin        // beat taken
                        beat[c]++;
                        if (beat[c] == hbm_cfg_pkg::BURST_BEATS) begin
                            beat[c] = 0;
                            q_rd[c]++;
                        end
                    end
                    // a pending beat stays put until it is taken
                    if (!r_valid_o[c] || r_ready_i[c]) begin
                        if (q_rd[c] != q_wr[c] && ($random(seed) & 3) != 0) begin
                            addr = ar_q[c][q_rd[c] % Q_DEPTH]
                                 + hbm_types_pkg::hbm_addr_t'(beat[c]);
                            r_valid_o[c]  <= 1'b1;
                            r_o[c].data   <= {32'(c), 32'(addr)};  // channel, byte address
                            r_o[c].last   <= (beat[c] == hbm_cfg_pkg::BURST_BEATS - 1);
                        end else begin
                            r_valid_o[c] <= 1'b0;
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_hbm_read_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hbm_read_top;

    typedef logic [hbm_cfg_pkg::ENGINE_DATA_W-1:0] cmp_t;   // widest compared value

    localparam int LOG_DEPTH      = 128;
    localparam int TOTAL_BURSTS   = 3 + 6 + 5;              // bursts per channel, all runs
    localparam int STALL_MARGIN   = 40;
    localparam int TIMEOUT_CYCLES = TOTAL_BURSTS * hbm_cfg_pkg::BURST_BEATS * STALL_MARGIN + 200;

    logic                                                          hbm_clk;
    logic                                                          hbm_rstn;
    logic                                                          start;
    hbm_types_pkg::burst_cnt_t                                     burst_cnt;
    hbm_types_pkg::hbm_addr_t                                      stride;
    logic [hbm_cfg_pkg::CHAN_NUM-1:0]                              ar_valid;
    logic [hbm_cfg_pkg::CHAN_NUM-1:0]                              ar_ready;
    logic [hbm_cfg_pkg::CHAN_NUM-1:0]                              r_valid;
    logic [hbm_cfg_pkg::CHAN_NUM-1:0]                              r_ready;
    hbm_types_pkg::ar_req_t [hbm_cfg_pkg::CHAN_NUM-1:0]            ar;
    hbm_types_pkg::r_beat_t [hbm_cfg_pkg::CHAN_NUM-1:0]            r;
    logic [hbm_cfg_pkg::ENGINE_NUM-1:0]                            eng_valid;
    logic [hbm_cfg_pkg::ENGINE_NUM-1:0]                            eng_credit;
    hbm_types_pkg::engine_data_t [hbm_cfg_pkg::ENGINE_NUM-1:0]     eng_data;
    logic                                                          start_um;
    logic                                                          busy;

    // request and word logs, bases mark the current run
    hbm_types_pkg::hbm_addr_t    ar_log  [hbm_cfg_pkg::CHAN_NUM][LOG_DEPTH];
    logic [7:0]                  len_log [hbm_cfg_pkg::CHAN_NUM][LOG_DEPTH];
    int                          ar_cnt  [hbm_cfg_pkg::CHAN_NUM] = '{default: 0};
    int                          ar_base [hbm_cfg_pkg::CHAN_NUM] = '{default: 0};
    hbm_types_pkg::engine_data_t rx_log  [hbm_cfg_pkg::ENGINE_NUM][LOG_DEPTH];
    int                          rx_cnt  [hbm_cfg_pkg::ENGINE_NUM] = '{default: 0};
    int                          rx_base [hbm_cfg_pkg::ENGINE_NUM] = '{default: 0};
    int                          credit_owed [hbm_cfg_pkg::ENGINE_NUM] = '{default: 0};
    logic                        credit_hold;      // engine keeps its credits
    int                          um_high = 0;
    int                          um_pulses = 0;
    int                          um_high_base;
    int                          um_pulse_base;
    logic                        um_prev = 1'b0;
    int                          cycles;

    initial begin
        hbm_clk = 1'b0;
        forever #5 hbm_clk = ~hbm_clk;   // 100 MHz
    end

    hbm_read_top hbm_read_top_inst (
        .hbm_clk      (hbm_clk),
        .hbm_rstn     (hbm_rstn),
        .start_i      (start),
        .burst_cnt_i  (burst_cnt),
        .stride_i     (stride),
        .ar_valid_o   (ar_valid),
        .ar_o         (ar),
        .ar_ready_i   (ar_ready),
        .r_valid_i    (r_valid),
        .r_i          (r),
        .r_ready_o    (r_ready),
        .eng_valid_o  (eng_valid),
        .eng_data_o   (eng_data),
        .eng_credit_i (eng_credit),
        .start_um_o   (start_um),
        .busy_o       (busy)
    );

    hbm_mem_model mem_model_inst (
        .hbm_clk    (hbm_clk),
        .hbm_rstn   (hbm_rstn),
        .ar_valid_i (ar_valid),
        .ar_i       (ar),
        .ar_ready_o (ar_ready),
        .r_valid_o  (r_valid),
        .r_o        (r),
        .r_ready_i  (r_ready)
    );

    //////////////////////////////////////////////////
    // engine model and bus monitors

    // one credit back per word, nothing while held
    task automatic return_credit(input int e);
        if (!credit_hold && credit_owed[e] > 0) begin
            eng_credit[e] <= 1'b1;
            credit_owed[e]--;
        end else begin
            eng_credit[e] <= 1'b0;
        end
    endtask

    initial begin
        eng_credit = '0;
        forever begin
            @(posedge hbm_clk);
            for (int c = 0; c < hbm_cfg_pkg::CHAN_NUM; c++) begin
                if (ar_valid[c] && ar_ready[c]) begin      // ar handshake
                    ar_log[c][ar_cnt[c]]  = ar[c].addr;
                    len_log[c][ar_cnt[c]] = ar[c].len;
                    ar_cnt[c]++;
                end
            end
            for (int e = 0; e < hbm_cfg_pkg::ENGINE_NUM; e++) begin
                if (eng_valid[e]) begin
                    rx_log[e][rx_cnt[e]] = eng_data[e];
                    rx_cnt[e]++;
                    credit_owed[e]++;
                end
                return_credit(e);
            end
            if (start_um) um_high++;
            if (start_um && !um_prev) um_pulses++;      // rising edge of start_um
            um_prev = start_um;
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge hbm_clk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("Errors found");
                $fatal(1, "simulation stopped by watchdog");
            end
        end
    end

    //////////////////////////////////////////////////
    // checking

    task automatic check_value(input string name, input cmp_t expected, input cmp_t actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            $display("Errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // beat n of a channel, burst n / BURST_BEATS at n / BURST_BEATS * stride
    function automatic hbm_types_pkg::chan_data_t expected_beat(input int c, input int n,
                                                               input int stride_bytes);
        hbm_types_pkg::hbm_addr_t a;
        a = hbm_types_pkg::hbm_addr_t'(n / hbm_cfg_pkg::BURST_BEATS)
          * hbm_types_pkg::hbm_addr_t'(stride_bytes)
          + hbm_types_pkg::hbm_addr_t'(n % hbm_cfg_pkg::BURST_BEATS);
        return {32'(c), 32'(a)};
    endfunction

    task automatic check_addresses(input string name, input int bursts, input int stride_bytes);
        for (int c = 0; c < hbm_cfg_pkg::CHAN_NUM; c++) begin
            check_value($sformatf("%s ch%0d request count", name, c),
                        cmp_t'(bursts), cmp_t'(ar_cnt[c] - ar_base[c]));
            for (int k = 0; k < bursts; k++) begin
                check_value($sformatf("%s ch%0d req %0d addr", name, c, k),
                            cmp_t'(hbm_types_pkg::hbm_addr_t'(k * stride_bytes)),
                            cmp_t'(ar_log[c][ar_base[c] + k]));
                check_value($sformatf("%s ch%0d req %0d len", name, c, k),
                            cmp_t'(hbm_cfg_pkg::BURST_BEATS - 1),
                            cmp_t'(len_log[c][ar_base[c] + k]));
            end
        end
    endtask

    task automatic check_words(input string name, input int bursts, input int stride_bytes);
        for (int e = 0; e < hbm_cfg_pkg::ENGINE_NUM; e++) begin
            for (int n = 0; n < bursts * hbm_cfg_pkg::BURST_BEATS; n++) begin
                check_value($sformatf("%s eng%0d word %0d", name, e, n),
                            {expected_beat(2 * e + 1, n, stride_bytes),   // odd channel high
                             expected_beat(2 * e, n, stride_bytes)},
                            rx_log[e][rx_base[e] + n]);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // run control

    task automatic launch_run(input int bursts, input int stride_bytes);
        for (int c = 0; c < hbm_cfg_pkg::CHAN_NUM; c++) ar_base[c] = ar_cnt[c];
        for (int e = 0; e < hbm_cfg_pkg::ENGINE_NUM; e++) rx_base[e] = rx_cnt[e];
        um_high_base  = um_high;
        um_pulse_base = um_pulses;
        @(posedge hbm_clk);
        burst_cnt <= hbm_types_pkg::burst_cnt_t'(bursts);
        stride    <= hbm_types_pkg::hbm_addr_t'(stride_bytes);
        start     <= 1'b1;
        while (!busy) @(posedge hbm_clk);               // edge, run_start, then busy
    endtask

    task automatic finish_run(input string name, input int bursts);
        while (busy) @(posedge hbm_clk);
        for (int e = 0; e < hbm_cfg_pkg::ENGINE_NUM; e++) begin   // all words in by now
            check_value($sformatf("%s eng%0d words at run end", name, e),
                        cmp_t'(bursts * hbm_cfg_pkg::BURST_BEATS), cmp_t'(rx_cnt[e] - rx_base[e]));
        end
        @(posedge hbm_clk);
        start <= 1'b0;
        repeat (3) @(posedge hbm_clk);                  // let the synchronizer see low
    endtask

    //////////////////////////////////////////////////
    // tests

    task automatic test_reset_state();
        repeat (8) @(posedge hbm_clk);
        check_value("reset r_ready", '0, cmp_t'(r_ready));
        hbm_rstn <= 1'b1;
        @(posedge hbm_clk);
        check_value("reset ar_valid", '0, cmp_t'(ar_valid));
        check_value("reset eng_valid", '0, cmp_t'(eng_valid));
        check_value("reset start_um", '0, cmp_t'(start_um));
        check_value("reset busy", '0, cmp_t'(busy));
    endtask

    task automatic test_start_pulse();
        launch_run(3, 64);
        repeat (3) @(posedge hbm_clk);                  // start still held high
        start <= 1'b0;
        repeat (2) @(posedge hbm_clk);
        start <= 1'b1;                                  // second edge while busy
        finish_run("start pulse", 3);
        check_value("start pulse start_um pulses", cmp_t'(1), cmp_t'(um_pulses - um_pulse_base));
        check_value("start pulse start_um cycles", cmp_t'(hbm_cfg_pkg::START_UM_CYCLES),
                    cmp_t'(um_high - um_high_base));
        check_addresses("start pulse", 3, 64);
        check_words("start pulse", 3, 64);
    endtask

    task automatic test_credit_backpressure();
        credit_hold = 1'b1;
        launch_run(6, 128);
        while (r_ready != '0) @(posedge hbm_clk);       // every fifo full
        repeat (10) @(posedge hbm_clk);
        for (int e = 0; e < hbm_cfg_pkg::ENGINE_NUM; e++) begin
            check_value($sformatf("credit hold eng%0d words", e),
                        cmp_t'(hbm_cfg_pkg::CREDIT_MAX), cmp_t'(rx_cnt[e] - rx_base[e]));
        end
        credit_hold = 1'b0;                             // engine drains again
        finish_run("credit hold", 6);
        check_addresses("credit hold", 6, 128);
        check_words("credit hold", 6, 128);
    endtask

    task automatic test_restart();
        launch_run(5, 200);
        finish_run("restart", 5);
        check_addresses("restart", 5, 200);
        check_words("restart", 5, 200);
    endtask

    initial begin
        hbm_rstn    = 1'b0;
        start       = 1'b0;
        burst_cnt   = '0;
        stride      = '0;
        credit_hold = 1'b0;
        test_reset_state();
        test_start_pulse();
        test_credit_backpressure();
        test_restart();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
